/* hw/apu_cfg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Sizes of the accelerator back end. The register file is 32 deep and
// the divider runs one quotient bit per cycle, so DivCycles == DataW
//////////////////////////////////////////////////////////////////////
`default_nettype none

package apu_cfg_pkg;

  // Register file geometry
  localparam int NumRegs  = 32;
  localparam int RegAddrW = 5;

  // Operand and result width
  localparam int DataW = 16;

  // One restoring step per quotient bit
  localparam int DivCycles = 16;

  typedef logic [RegAddrW-1:0] reg_addr_t;
  typedef logic [DataW-1:0]    data_t;

  // Latency class 0..3, class 3 is the multicycle divider
  typedef logic [1:0]          lat_t;

  // Divider step counter, wide enough to hold DivCycles
  typedef logic [$clog2(DivCycles+1)-1:0] div_cnt_t;

endpackage

`default_nettype wire

/* hw/apu_op_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Operation encoding and decode helpers. All arithmetic is unsigned
//////////////////////////////////////////////////////////////////////
`default_nettype none

package apu_op_pkg;

  typedef enum logic [2:0] {
    OP_LDI,
    OP_ADD,
    OP_SUB,
    OP_NEG,
    OP_MUL,
    OP_DIV
  } op_e;

  // Latency class of each operation
  function automatic apu_cfg_pkg::lat_t op_lat(op_e op);
    case (op)
      OP_MUL:  return 2'd2;
      OP_DIV:  return 2'd3;
      // LDI, ADD, SUB and NEG go through the single register stage
      default: return 2'd1;
    endcase
  endfunction

  // LDI takes its operand from the immediate only
  function automatic logic op_uses_rs1(op_e op);
    return op != OP_LDI;
  endfunction

  // Two-operand operations
  function automatic logic op_uses_rs2(op_e op);
    return (op == OP_ADD) || (op == OP_SUB) ||
           (op == OP_MUL) || (op == OP_DIV);
  endfunction

endpackage

`default_nettype wire

/* hw/apu_issue.sv */
//////////////////////////////////////////////////////////////////////
// One-entry issue register. The driver must hold the instruction
// while ins_stall_o is high. Operands are re-read every cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apu_issue (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         ins_valid_i,
  input  apu_op_pkg::op_e              ins_op_i,
  input  apu_cfg_pkg::reg_addr_t       ins_rd_i,
  input  apu_cfg_pkg::reg_addr_t       ins_rs1_i,
  input  apu_cfg_pkg::reg_addr_t       ins_rs2_i,
  input  apu_cfg_pkg::data_t           ins_imm_i,
  output logic                         ins_stall_o,
  output apu_cfg_pkg::reg_addr_t       rs1_addr_o,
  output apu_cfg_pkg::reg_addr_t       rs2_addr_o,
  input  apu_cfg_pkg::data_t           rs1_data_i,
  input  apu_cfg_pkg::data_t           rs2_data_i,
  output logic                         iss_valid_o,
  output apu_cfg_pkg::lat_t            iss_lat_o,
  output apu_cfg_pkg::reg_addr_t       iss_rd_o,
  output apu_cfg_pkg::reg_addr_t [1:0] iss_srcs_o,
  output logic [1:0]                   iss_srcs_valid_o,
  input  logic                         disp_stall_i,
  input  logic                         read_dep_i,
  input  logic                         write_dep_i,
  output apu_op_pkg::op_e              iss_op_o,
  output apu_cfg_pkg::data_t           op_a_o,
  output apu_cfg_pkg::data_t           op_b_o
);
  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  logic      valid_q;
  op_e       op_q;
  reg_addr_t rd_q;
  reg_addr_t rs1_q;
  reg_addr_t rs2_q;
  data_t     imm_q;
  logic      take;
  logic      leave;

  // Held instruction leaves once the dispatcher sees no stall and no hazard
  assign leave       = valid_q & ~(disp_stall_i | read_dep_i | write_dep_i);
  assign ins_stall_o = valid_q & ~leave;
  // A new instruction may enter in the same cycle the old one leaves
  assign take        = ins_valid_i & ~ins_stall_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (leave) begin
      valid_q <= 1'b0;
    end
  end

  // Instruction payload
  always_ff @(posedge clk_i) begin
    if (take) begin
      op_q  <= ins_op_i;
      rd_q  <= ins_rd_i;
      rs1_q <= ins_rs1_i;
      rs2_q <= ins_rs2_i;
      imm_q <= ins_imm_i;
    end
  end

  // Register file reads, bypassed writes show up here
  assign rs1_addr_o = rs1_q;
  assign rs2_addr_o = rs2_q;

  // Decode towards the dispatcher
  assign iss_valid_o         = valid_q;
  assign iss_lat_o           = op_lat(op_q);
  assign iss_rd_o            = rd_q;
  assign iss_srcs_o[0]       = rs1_q;
  assign iss_srcs_o[1]       = rs2_q;
  assign iss_srcs_valid_o[0] = op_uses_rs1(op_q);
  assign iss_srcs_valid_o[1] = op_uses_rs2(op_q);

  // Operands towards the unit; LDI puts the immediate on port A
  assign iss_op_o = op_q;
  assign op_a_o   = (op_q == OP_LDI) ? imm_q : rs1_data_i;
  assign op_b_o   = rs2_data_i;

endmodule

`default_nettype wire

/* hw/apu_disp.sv */
//////////////////////////////////////////////////////////////////////
// Dispatcher with two unreturned slots. Results must come back in
// request order; the type stall keeps that true for classes 1..3
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apu_disp (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         enable_i,
  input  apu_cfg_pkg::lat_t            apu_lat_i,
  input  apu_cfg_pkg::reg_addr_t       apu_waddr_i,
  output apu_cfg_pkg::reg_addr_t       apu_waddr_o,
  output logic                         active_o,
  output logic                         stall_o,
  output logic                         perf_type_o,
  input  logic                         is_decoding_i,
  input  apu_cfg_pkg::reg_addr_t [1:0] read_regs_i,
  input  logic [1:0]                   read_regs_valid_i,
  output logic                         read_dep_o,
  input  apu_cfg_pkg::reg_addr_t       write_reg_i,
  input  logic                         write_reg_valid_i,
  output logic                         write_dep_o,
  output logic                         perf_cont_o,
  output logic                         apu_req_o,
  input  logic                         apu_gnt_i,
  input  logic                         apu_rvalid_i
);
  import apu_cfg_pkg::*;

  reg_addr_t  addr_inflight_q, addr_waiting_q;
  reg_addr_t  addr_inflight_d, addr_waiting_d;
  logic       valid_inflight_q, valid_waiting_q;
  logic       valid_inflight_d, valid_waiting_d;
  logic       valid_req, req_accepted;
  logic       returned_req, returned_inflight, returned_waiting;
  logic       active;
  lat_t       lat_q;
  logic [1:0] rd_deps_inflight, rd_deps_waiting;
  logic       read_dep, write_dep;
  logic       stall_full, stall_type, stall_nack;

  // Request only when nothing but a missing grant holds it back
  assign valid_req    = enable_i & ~(stall_full | stall_type | read_dep | write_dep);
  assign req_accepted = valid_req & apu_gnt_i;

  ////////////////////////////////////////////////////////////////////
  // Slot tracking
  ////////////////////////////////////////////////////////////////////

  // The oldest unreturned entry owns the current return
  assign returned_req      = valid_req & apu_rvalid_i & ~valid_inflight_q & ~valid_waiting_q;
  assign returned_inflight = valid_inflight_q & apu_rvalid_i & ~valid_waiting_q;
  assign returned_waiting  = valid_waiting_q & apu_rvalid_i;

  always_comb begin
    valid_inflight_d = valid_inflight_q;
    valid_waiting_d  = valid_waiting_q;
    addr_inflight_d  = addr_inflight_q;
    addr_waiting_d   = addr_waiting_q;
    if (req_accepted && !returned_req) begin
      // New entry always goes to the in-flight slot
      valid_inflight_d = 1'b1;
      addr_inflight_d  = apu_waddr_i;
      // Older in-flight entry that stays moves to waiting
      if ((valid_inflight_q && !returned_inflight) || returned_waiting) begin
        valid_waiting_d = 1'b1;
        addr_waiting_d  = addr_inflight_q;
      end
    end else if (returned_inflight) begin
      valid_inflight_d = 1'b0;
      valid_waiting_d  = 1'b0;
    end else if (returned_waiting) begin
      valid_waiting_d  = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight_q <= 1'b0;
      valid_waiting_q  <= 1'b0;
      addr_inflight_q  <= '0;
      addr_waiting_q   <= '0;
    end else begin
      valid_inflight_q <= valid_inflight_d;
      valid_waiting_q  <= valid_waiting_d;
      addr_inflight_q  <= addr_inflight_d;
      addr_waiting_q   <= addr_waiting_d;
    end
  end

  assign active = valid_inflight_q | valid_waiting_q;

  // Class of the youngest accepted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lat_q <= '0;
    end else if (req_accepted) begin
      lat_q <= apu_lat_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Hazards against slots that do not return this cycle
  ////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : g_rd_dep
    assign rd_deps_inflight[i] = read_regs_valid_i[i] & (read_regs_i[i] == addr_inflight_q);
    assign rd_deps_waiting[i]  = read_regs_valid_i[i] & (read_regs_i[i] == addr_waiting_q);
  end

  assign read_dep  = is_decoding_i &
                     ((|rd_deps_inflight & valid_inflight_q & ~returned_inflight) |
                      (|rd_deps_waiting & valid_waiting_q & ~returned_waiting));
  // Same destination still pending
  assign write_dep = is_decoding_i & write_reg_valid_i &
                     (((write_reg_i == addr_inflight_q) & valid_inflight_q & ~returned_inflight) |
                      ((write_reg_i == addr_waiting_q) & valid_waiting_q & ~returned_waiting));

  assign read_dep_o  = read_dep;
  assign write_dep_o = write_dep;

  ////////////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////////////

  // Both slots taken
  assign stall_full = valid_inflight_q & valid_waiting_q;
  // Shorter class would overtake, class 3 waits for an idle unit
  assign stall_type = enable_i & active & ((apu_lat_i < lat_q) | (apu_lat_i == 2'd3));
  // Unit refused the grant
  assign stall_nack = valid_req & ~apu_gnt_i;
  assign stall_o    = stall_full | stall_type | stall_nack;

  assign apu_req_o   = valid_req;
  assign active_o    = active;
  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  // Write-back address from whichever slot returns
  always_comb begin
    apu_waddr_o = '0;
    if (returned_req) begin
      apu_waddr_o = apu_waddr_i;
    end
    if (returned_inflight) begin
      apu_waddr_o = addr_inflight_q;
    end
    if (returned_waiting) begin
      apu_waddr_o = addr_waiting_q;
    end
  end

endmodule

`default_nettype wire

/* hw/apu_unit.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator unit with three result paths. Paths share one result
// port; the dispatcher keeps their results from meeting
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apu_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  apu_op_pkg::op_e    op_i,
  input  apu_cfg_pkg::data_t op_a_i,
  input  apu_cfg_pkg::data_t op_b_i,
  input  apu_cfg_pkg::lat_t  lat_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output apu_cfg_pkg::data_t rdata_o
);
  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  logic         accept;
  data_t        alu_res;
  logic         alu_vld_q;
  data_t        alu_res_q;
  logic [1:0]   mul_vld_q;
  data_t        mul_lo_q;
  logic [7:0]   mul_hi_q;
  data_t        mul_res_q;
  logic         div_busy_q;
  logic         div_done_q;
  div_cnt_t     div_cnt_q;
  data_t        div_quo_q;
  data_t        div_rem_q;
  data_t        div_dvs_q;
  logic [DataW:0] div_shift;
  logic         div_fits;

  // Only the busy divider refuses work
  assign gnt_o  = ~div_busy_q;
  assign accept = req_i & gnt_o;

  // Class 1 arithmetic, LDI passes operand A
  always_comb begin
    case (op_i)
      OP_ADD:  alu_res = op_a_i + op_b_i;
      OP_SUB:  alu_res = op_a_i - op_b_i;
      OP_NEG:  alu_res = '0 - op_a_i;
      default: alu_res = op_a_i;
    endcase
  end

  // Restoring step: shift in the next dividend bit, subtract if it fits
  assign div_shift = {div_rem_q, div_quo_q[DataW-1]};
  assign div_fits  = div_shift >= {1'b0, div_dvs_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_vld_q  <= 1'b0;
      mul_vld_q  <= '0;
      div_busy_q <= 1'b0;
      div_done_q <= 1'b0;
      div_cnt_q  <= '0;
    end else begin
      alu_vld_q  <= accept & (lat_i == 2'd1);
      mul_vld_q  <= {mul_vld_q[0], accept & (lat_i == 2'd2)};
      // Last step strobes done together with the final quotient bit
      div_done_q <= div_busy_q & (div_cnt_q == div_cnt_t'(1));
      if (accept && lat_i == 2'd3) begin
        div_busy_q <= 1'b1;
        div_cnt_q  <= div_cnt_t'(DivCycles);
      end else if (div_busy_q) begin
        div_cnt_q <= div_cnt_q - div_cnt_t'(1);
        if (div_cnt_q == div_cnt_t'(1)) begin
          div_busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      alu_res_q <= alu_res;
    end
    // Multiply stage 1 splits operand B into two byte partial products
    mul_lo_q  <= op_a_i * op_b_i[7:0];
    mul_hi_q  <= op_a_i[7:0] * op_b_i[15:8];
    // Stage 2 adds them, low half of the product only
    mul_res_q <= mul_lo_q + {mul_hi_q, 8'h00};
    // Divisor zero always fits, giving an all-ones quotient
    if (accept && lat_i == 2'd3) begin
      div_quo_q <= op_a_i;
      div_rem_q <= '0;
      div_dvs_q <= op_b_i;
    end else if (div_busy_q) begin
      div_quo_q <= {div_quo_q[DataW-2:0], div_fits};
      div_rem_q <= div_fits ? data_t'(div_shift - {1'b0, div_dvs_q}) : div_shift[DataW-1:0];
    end
  end

  // At most one path is valid in any cycle
  assign rvalid_o = alu_vld_q | mul_vld_q[1] | div_done_q;

  always_comb begin
    rdata_o = alu_res_q;
    if (mul_vld_q[1]) begin
      rdata_o = mul_res_q;
    end
    if (div_done_q) begin
      rdata_o = div_quo_q;
    end
  end

endmodule

`default_nettype wire

/* hw/apu_regfile.sv */
//////////////////////////////////////////////////////////////////////
// Result register file, one write and two read ports. Reads see a
// same-cycle write through the bypass
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apu_regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   we_i,
  input  apu_cfg_pkg::reg_addr_t waddr_i,
  input  apu_cfg_pkg::data_t     wdata_i,
  input  apu_cfg_pkg::reg_addr_t raddr_a_i,
  input  apu_cfg_pkg::reg_addr_t raddr_b_i,
  output apu_cfg_pkg::data_t     rdata_a_o,
  output apu_cfg_pkg::data_t     rdata_b_o
);
  import apu_cfg_pkg::*;

  data_t regs_q [NumRegs];

  // All entries start at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Write-to-read bypass
  assign rdata_a_o = (we_i && (waddr_i == raddr_a_i)) ? wdata_i : regs_q[raddr_a_i];
  assign rdata_b_o = (we_i && (waddr_i == raddr_b_i)) ? wdata_i : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* hw/apu_sub_top.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator back end top. Write-back leaves in program order
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apu_sub_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ins_valid_i,
  input  apu_op_pkg::op_e        ins_op_i,
  input  apu_cfg_pkg::reg_addr_t ins_rd_i,
  input  apu_cfg_pkg::reg_addr_t ins_rs1_i,
  input  apu_cfg_pkg::reg_addr_t ins_rs2_i,
  input  apu_cfg_pkg::data_t     ins_imm_i,
  output logic                   ins_stall_o,
  output logic                   wb_valid_o,
  output apu_cfg_pkg::reg_addr_t wb_addr_o,
  output apu_cfg_pkg::data_t     wb_data_o,
  output logic                   active_o,
  output logic                   perf_type_o,
  output logic                   perf_cont_o
);
  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  reg_addr_t       rs1_addr, rs2_addr;
  data_t           rs1_data, rs2_data;
  logic            iss_valid;
  lat_t            iss_lat;
  reg_addr_t       iss_rd;
  reg_addr_t [1:0] iss_srcs;
  logic [1:0]      iss_srcs_valid;
  logic            disp_stall, read_dep, write_dep;
  op_e             iss_op;
  data_t           op_a, op_b;
  logic            apu_req, apu_gnt, apu_rvalid;
  reg_addr_t       apu_waddr;
  data_t           apu_rdata;

  apu_issue u_issue (
    .clk_i, .rst_ni,
    .ins_valid_i, .ins_op_i, .ins_rd_i, .ins_rs1_i, .ins_rs2_i, .ins_imm_i, .ins_stall_o,
    .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
    .iss_valid_o (iss_valid), .iss_lat_o (iss_lat), .iss_rd_o (iss_rd),
    .iss_srcs_o (iss_srcs), .iss_srcs_valid_o (iss_srcs_valid),
    .disp_stall_i (disp_stall), .read_dep_i (read_dep), .write_dep_i (write_dep),
    .iss_op_o (iss_op), .op_a_o (op_a), .op_b_o (op_b)
  );

  // Every operation writes rd, so the destination is valid with the issue slot
  apu_disp u_disp (
    .clk_i, .rst_ni,
    .enable_i (iss_valid), .apu_lat_i (iss_lat), .apu_waddr_i (iss_rd),
    .apu_waddr_o (apu_waddr), .active_o, .stall_o (disp_stall), .perf_type_o,
    .is_decoding_i (iss_valid), .read_regs_i (iss_srcs),
    .read_regs_valid_i (iss_srcs_valid), .read_dep_o (read_dep),
    .write_reg_i (iss_rd), .write_reg_valid_i (iss_valid), .write_dep_o (write_dep),
    .perf_cont_o, .apu_req_o (apu_req), .apu_gnt_i (apu_gnt), .apu_rvalid_i (apu_rvalid)
  );

  apu_unit u_unit (
    .clk_i, .rst_ni,
    .req_i (apu_req), .op_i (iss_op), .op_a_i (op_a), .op_b_i (op_b), .lat_i (iss_lat),
    .gnt_o (apu_gnt), .rvalid_o (apu_rvalid), .rdata_o (apu_rdata)
  );

  apu_regfile u_regfile (
    .clk_i, .rst_ni,
    .we_i (apu_rvalid), .waddr_i (apu_waddr), .wdata_i (apu_rdata),
    .raddr_a_i (rs1_addr), .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data), .rdata_b_o (rs2_data)
  );

  // Write-back port mirrors the register file write
  assign wb_valid_o = apu_rvalid;
  assign wb_addr_o  = apu_waddr;
  assign wb_data_o  = apu_rdata;

endmodule

`default_nettype wire

/* verif/apu_chk.sv */
//////////////////////////////////////////////////////////////////////
// Protocol checks bound into each apu_disp. Class 0 returns count as
// owned by the request of the same cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apu_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic inflight_i,
  input logic waiting_i,
  input logic stall_i
);

  // Granted requests still waiting for their result
  logic [2:0] pend_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_q + 3'(req_i & gnt_i) - 3'(rvalid_i);
    end
  end

  // Every return belongs to a request or an unreturned slot
  a_ret_owner : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> (req_i | inflight_i | waiting_i))
    else $error("Result returned with no request and no unreturned slot");

  // Two granted results outstanding fill both slots, so issue must hold
  a_full_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pend_q == 3'd2) |-> stall_i)
    else $error("Stall low while both slots are full");

  // A result needs an earlier grant
  a_grant_first : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> (pend_q != '0))
    else $error("Result valid without an earlier grant");

endmodule

bind apu_disp apu_chk u_chk (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_i      (apu_req_o),
  .gnt_i      (apu_gnt_i),
  .rvalid_i   (apu_rvalid_i),
  .inflight_i (valid_inflight_q),
  .waiting_i  (valid_waiting_q),
  .stall_i    (stall_o)
);

`default_nettype wire

/* verif/apu_tb.sv */
//////////////////////////////////////////////////////////////////////
// Table-driven testbench. Expected write-backs come from a register
// model run in program order; the run stops at the first error
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apu_tb;
  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  localparam int NumRows    = 28;
  localparam int StallLimit = 200;
  localparam int DrainLimit = 400;

  logic      clk_i;
  logic      rst_ni;
  logic      ins_valid;
  op_e       ins_op;
  reg_addr_t ins_rd, ins_rs1, ins_rs2;
  data_t     ins_imm;
  logic      ins_stall;
  logic      wb_valid;
  reg_addr_t wb_addr;
  data_t     wb_data;
  logic      active, perf_type, perf_cont;

  // Stimulus table
  op_e       tab_op  [NumRows];
  reg_addr_t tab_rd  [NumRows];
  reg_addr_t tab_rs1 [NumRows];
  reg_addr_t tab_rs2 [NumRows];
  data_t     tab_imm [NumRows];
  int        tab_gap [NumRows];
  int        row_cnt;

  // Reference register file and expected write-backs in order
  data_t     model_regs [NumRegs];
  reg_addr_t exp_addr_q [$];
  data_t     exp_data_q [$];
  int        exp_take_q [$];
  int        exp_lat_q  [$];
  bit        exp_exact_q [$];

  int cyc;
  bit seen_stall, seen_type, seen_cont;

  apu_sub_top dut (
    .clk_i, .rst_ni,
    .ins_valid_i (ins_valid), .ins_op_i (ins_op), .ins_rd_i (ins_rd),
    .ins_rs1_i (ins_rs1), .ins_rs2_i (ins_rs2), .ins_imm_i (ins_imm),
    .ins_stall_o (ins_stall),
    .wb_valid_o (wb_valid), .wb_addr_o (wb_addr), .wb_data_o (wb_data),
    .active_o (active), .perf_type_o (perf_type), .perf_cont_o (perf_cont)
  );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  // Unsigned 16-bit results, divide by zero gives all ones
  function automatic data_t model_result(op_e op, data_t a, data_t b, data_t imm);
    case (op)
      OP_LDI:  return imm;
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_NEG:  return ~a + data_t'(1);
      OP_MUL:  return data_t'(a * b);
      OP_DIV:  return (b == '0) ? '1 : a / b;
      default: return '0;
    endcase
  endfunction

  // Cycles from the taking edge to the strobe on an idle DUT
  function automatic int result_latency(op_e op);
    case (op)
      OP_MUL:  return 2;
      OP_DIV:  return DivCycles + 1;
      default: return 1;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic expect_seen(input bit seen, input string what);
    if (!seen) begin
      $display("Expected to observe %s, but it never appeared", what);
      stop_run();
    end
  endtask

  task automatic check_writeback();
    int lat;
    int min_lat;
    bit exact;
    if (exp_addr_q.size() == 0) begin
      $display("Write-back to register %0d arrived with no result expected", wb_addr);
      stop_run();
    end else begin
      check_addr("wb_addr_o", wb_addr, exp_addr_q.pop_front());
      check_data("wb_data_o", wb_data, exp_data_q.pop_front());
      exact   = exp_exact_q.pop_front();
      min_lat = exp_lat_q.pop_front();
      lat     = cyc - exp_take_q.pop_front();
      if ((exact && lat != min_lat) || lat < min_lat) begin
        $display("Write-back to register %0d took %0d cycles, expected %0d (exact: %0d)",
                 wb_addr, lat, min_lat, exact);
        stop_run();
      end
    end
  endtask

  // Outputs sampled mid-cycle where they are settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (ins_stall) seen_stall = 1'b1;
      if (perf_type) seen_type = 1'b1;
      if (perf_cont) seen_cont = 1'b1;
      if (wb_valid) check_writeback();
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  task automatic add_row(input op_e op, input int rd, input int rs1, input int rs2,
                         input data_t imm, input int gap);
    tab_op[row_cnt]  = op;
    tab_rd[row_cnt]  = reg_addr_t'(rd);
    tab_rs1[row_cnt] = reg_addr_t'(rs1);
    tab_rs2[row_cnt] = reg_addr_t'(rs2);
    tab_imm[row_cnt] = imm;
    tab_gap[row_cnt] = gap;
    row_cnt++;
  endtask

  task automatic build_table();
    row_cnt = 0;
    // Rows 0..4, class 1 on loaded registers
    add_row(OP_LDI, 1, 0, 0, data_t'($urandom), 2);
    add_row(OP_LDI, 2, 0, 0, data_t'($urandom), 2);
    add_row(OP_ADD, 3, 1, 2, data_t'($urandom), 2);
    add_row(OP_SUB, 4, 1, 2, data_t'($urandom), 2);
    add_row(OP_NEG, 5, 1, 0, data_t'($urandom), 2);
    // Rows 5..8, MUL with a dependent ADD right behind
    add_row(OP_LDI, 6, 0, 0, data_t'($urandom), 2);
    add_row(OP_LDI, 7, 0, 0, data_t'($urandom), 2);
    add_row(OP_MUL, 8, 6, 7, data_t'($urandom), 0);
    add_row(OP_ADD, 9, 8, 6, data_t'($urandom), 2);
    // Rows 9..10, independent ADD after MUL
    add_row(OP_MUL, 10, 6, 7, data_t'($urandom), 0);
    add_row(OP_ADD, 11, 1, 2, data_t'($urandom), 2);
    // Rows 11..15, back-to-back DIVs, r13 is zero
    add_row(OP_LDI, 12, 0, 0, data_t'($urandom), 2);
    add_row(OP_LDI, 13, 0, 0, '0, 2);
    add_row(OP_DIV, 14, 12, 7, data_t'($urandom), 0);
    add_row(OP_DIV, 15, 12, 13, data_t'($urandom), 0);
    add_row(OP_DIV, 16, 15, 6, data_t'($urandom), 2);
    // Rows 16..27, mixed traffic with random gaps
    add_row(OP_LDI, 20, 0, 0, data_t'($urandom), int'($urandom % 4));
    add_row(OP_LDI, 21, 0, 0, data_t'($urandom), int'($urandom % 4));
    add_row(OP_ADD, 22, 20, 21, data_t'($urandom), int'($urandom % 4));
    add_row(OP_MUL, 23, 22, 21, data_t'($urandom), int'($urandom % 4));
    add_row(OP_SUB, 24, 23, 20, data_t'($urandom), int'($urandom % 4));
    add_row(OP_DIV, 25, 23, 21, data_t'($urandom), int'($urandom % 4));
    add_row(OP_NEG, 26, 25, 0, data_t'($urandom), int'($urandom % 4));
    add_row(OP_ADD, 20, 26, 24, data_t'($urandom), int'($urandom % 4));
    add_row(OP_MUL, 27, 20, 20, data_t'($urandom), int'($urandom % 4));
    add_row(OP_DIV, 28, 27, 22, data_t'($urandom), int'($urandom % 4));
    add_row(OP_LDI, 22, 0, 0, data_t'($urandom), int'($urandom % 4));
    add_row(OP_ADD, 29, 28, 22, data_t'($urandom), int'($urandom % 4));
  endtask

  // Called 10 ns after a rising edge; returns 10 ns after the taking edge
  task automatic send_row(input int idx);
    int    waited;
    data_t res;
    ins_valid = 1'b1;
    ins_op    = tab_op[idx];
    ins_rd    = tab_rd[idx];
    ins_rs1   = tab_rs1[idx];
    ins_rs2   = tab_rs2[idx];
    ins_imm   = tab_imm[idx];
    waited    = 0;
    @(negedge clk_i);
    while (ins_stall) begin
      waited++;
      if (waited > StallLimit) begin
        $display("Row %0d was never taken, ins_stall_o stayed high", idx);
        stop_run();
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
    // An empty queue means an idle DUT, so the latency must be exact
    res = model_result(tab_op[idx], model_regs[tab_rs1[idx]], model_regs[tab_rs2[idx]],
                       tab_imm[idx]);
    exp_exact_q.push_back(exp_addr_q.size() == 0);
    exp_addr_q.push_back(tab_rd[idx]);
    exp_data_q.push_back(res);
    exp_take_q.push_back(cyc);
    exp_lat_q.push_back(result_latency(tab_op[idx]));
    model_regs[tab_rd[idx]] = res;
    ins_valid = 1'b0;
  endtask

  task automatic run_rows(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      send_row(i);
      if (tab_gap[i] > 0) begin
        repeat (tab_gap[i]) @(posedge clk_i);
        #10;
      end
    end
  endtask

  // Polled 10 ns after each rising edge, away from the mid-cycle pops
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_addr_q.size() != 0) begin
      waited++;
      if (waited > DrainLimit) begin
        $display("Results did not drain, %0d still expected", exp_addr_q.size());
        stop_run();
      end
      @(posedge clk_i);
      #10;
    end
  endtask

  initial begin
    void'($urandom(32'hfb1));
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    ins_valid = 1'b0;
    ins_op    = OP_LDI;
    ins_rd    = '0;
    ins_rs1   = '0;
    ins_rs2   = '0;
    ins_imm   = '0;
    cyc       = 0;
    for (int i = 0; i < NumRegs; i++) begin
      model_regs[i] = '0;
    end
    build_table();
    repeat (2) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (ins_stall || wb_valid || active || perf_type || perf_cont) begin
      $display("Outputs were not all low after reset");
      stop_run();
    end
    @(posedge clk_i);
    #10;

    run_rows(0, 4);
    drain();

    seen_stall = 1'b0;
    run_rows(5, 8);
    drain();
    expect_seen(seen_stall, "ins_stall_o behind the MUL");

    seen_type = 1'b0;
    run_rows(9, 10);
    drain();
    expect_seen(seen_type, "perf_type_o for ADD after MUL");

    seen_stall = 1'b0;
    seen_cont  = 1'b0;
    run_rows(11, 15);
    drain();
    expect_seen(seen_stall | seen_cont, "a stall on back-to-back DIVs");

    run_rows(16, NumRows - 1);
    drain();

    // Last slot clears at the edge after its write-back
    if (active) begin
      $display("active_o still high after the last write-back");
      stop_run();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* files.f */
hw/apu_cfg_pkg.sv
hw/apu_op_pkg.sv
hw/apu_issue.sv
hw/apu_disp.sv
hw/apu_unit.sv
hw/apu_regfile.sv
hw/apu_sub_top.sv
verif/apu_chk.sv
verif/apu_tb.sv
